// File: verilog/ex_cfg.svh
`ifndef EX_CFG_SVH
`define EX_CFG_SVH

// ==========================================================================
// execute lane configuration
// ==========================================================================

// data path and pc width.
`define EX_XLEN 32

// destination register index width.
`define EX_REG_W 5

// opcode width, the top two bits carry the unit class.
`define EX_OP_W 5

// link address increment for jirl.
`define EX_PC_STEP 4

// shift and subtract steps of the divider.
`define EX_DIV_CYCLES 32

`endif

// File: verilog/ex_pkg.sv
`default_nettype none
`include "ex_cfg.svh"

package ex_pkg;

    // ======================================================================
    // opcodes: 0xxxx alu, 10xxx multiply, 11xxx divide
    // ======================================================================
    typedef enum logic [`EX_OP_W-1:0] {
        OP_ADD   = 5'h00,
        OP_SUB   = 5'h01,
        OP_SLT   = 5'h02,
        OP_SLTU  = 5'h03,
        OP_AND   = 5'h04,
        OP_OR    = 5'h05,
        OP_XOR   = 5'h06,
        OP_NOR   = 5'h07,
        OP_SLL   = 5'h08,
        OP_SRL   = 5'h09,
        OP_SRA   = 5'h0a,
        OP_LUI   = 5'h0b,
        OP_MUL   = 5'h10,
        OP_MULH  = 5'h11,
        OP_MULHU = 5'h12,
        OP_DIV   = 5'h18,
        OP_DIVU  = 5'h19,
        OP_MOD   = 5'h1a,
        OP_MODU  = 5'h1b
    } ex_opcode_t;

    typedef enum logic [1:0] {
        CLASS_ALU = 2'd0,
        CLASS_MUL = 2'd1,
        CLASS_DIV = 2'd2
    } ex_class_t;

    typedef struct packed {
        logic [`EX_XLEN-1:0]  pc;
        ex_opcode_t           opcode;
        logic [`EX_XLEN-1:0]  src1;
        logic [`EX_XLEN-1:0]  src2;
        logic [`EX_REG_W-1:0] dest;
        logic                 is_branch;
        logic                 branch_condition; // taken when alu bit 0 equals this.
        logic [`EX_XLEN-1:0]  branch_target;
        logic                 is_jirl;
        logic                 pred_taken;
        logic [`EX_XLEN-1:0]  pred_target;
    } ex_uop_t;

    typedef struct packed {
        logic [`EX_XLEN-1:0]  pc;
        logic [`EX_REG_W-1:0] dest;
        logic [`EX_XLEN-1:0]  result;
        logic                 branch_taken;
        logic [`EX_XLEN-1:0]  branch_target;
        logic                 mispredict;
    } ex_result_t;

endpackage

`default_nettype wire

// File: verilog/ex_alu.sv
`timescale 1ns/1ps
`default_nettype none
`include "ex_cfg.svh"

module ex_alu (
    input  wire ex_pkg::ex_opcode_t    op,
    input  wire [`EX_XLEN-1:0]         src1,
    input  wire [`EX_XLEN-1:0]         src2,
    output logic [`EX_XLEN-1:0]        result
);

    localparam int SH_W = $clog2(`EX_XLEN);

    logic [SH_W-1:0]     shamt;
    logic                lt_signed;
    logic                lt_unsigned;

    assign shamt       = src2[SH_W-1:0];
    assign lt_signed   = $signed(src1) < $signed(src2);
    assign lt_unsigned = src1 < src2;

    // ======================================================================
    // operation select
    // ======================================================================
    always_comb begin
        case (op)
            ex_pkg::OP_ADD:  result = src1 + src2;
            ex_pkg::OP_SUB:  result = src1 - src2;
            ex_pkg::OP_SLT:  result = {{(`EX_XLEN-1){1'b0}}, lt_signed};
            ex_pkg::OP_SLTU: result = {{(`EX_XLEN-1){1'b0}}, lt_unsigned};
            ex_pkg::OP_AND:  result = src1 & src2;
            ex_pkg::OP_OR:   result = src1 | src2;
            ex_pkg::OP_XOR:  result = src1 ^ src2;
            ex_pkg::OP_NOR:  result = ~(src1 | src2);
            ex_pkg::OP_SLL:  result = src1 << shamt;
            ex_pkg::OP_SRL:  result = src1 >> shamt;
            ex_pkg::OP_SRA:  result = $unsigned($signed(src1) >>> shamt);
            ex_pkg::OP_LUI:  result = src2; // the upper immediate is already placed.
            default:         result = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/ex_mul_unit.sv
`timescale 1ns/1ps
`default_nettype none
`include "ex_cfg.svh"

module ex_mul_unit (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        launch,
    input  wire ex_pkg::ex_opcode_t    op,
    input  wire [`EX_XLEN-1:0]         src1,
    input  wire [`EX_XLEN-1:0]         src2,
    output logic                       done,
    output logic [2*`EX_XLEN-1:0]      product
);

    logic                           start;
    logic                           sign_ex;
    logic signed [`EX_XLEN:0]       mul_a;
    logic signed [`EX_XLEN:0]       mul_b;
    logic signed [2*`EX_XLEN+1:0]   full;
    logic                           done_q;

    assign start   = launch && (op[4:3] == 2'b10);
    assign sign_ex = (op == ex_pkg::OP_MULH);

    // one extra bit lets a single signed multiplier cover mulh and mulhu.
    assign mul_a = {sign_ex && src1[`EX_XLEN-1], src1};
    assign mul_b = {sign_ex && src2[`EX_XLEN-1], src2};
    assign full  = mul_a * mul_b;

    always_ff @(posedge clk) begin
        if (start) begin
            product <= full[2*`EX_XLEN-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            done_q <= 1'b0;
        end else if (start) begin
            done_q <= 1'b1;
        end
    end

    // a new launch hides the previous op's done flag.
    assign done = done_q && !start;

endmodule

`default_nettype wire

// File: verilog/ex_div_unit.sv
`timescale 1ns/1ps
`default_nettype none
`include "ex_cfg.svh"

module ex_div_unit (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        flush,
    input  wire                        launch,
    input  wire ex_pkg::ex_opcode_t    op,
    input  wire [`EX_XLEN-1:0]         src1,
    input  wire [`EX_XLEN-1:0]         src2,
    output logic                       done,
    output logic [`EX_XLEN-1:0]        quotient,
    output logic [`EX_XLEN-1:0]        remainder
);

    localparam int XLEN  = `EX_XLEN;
    localparam int CNT_W = $clog2(`EX_DIV_CYCLES);

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        FIX
    } div_state_t;

    div_state_t          state;
    logic                start;
    logic                is_signed;
    logic [XLEN-1:0]     src1_mag;
    logic [XLEN-1:0]     src2_mag;
    logic [CNT_W-1:0]    count;
    logic [XLEN-1:0]     divisor;
    logic [XLEN-1:0]     quo_mag;
    logic [XLEN-1:0]     rem_mag;
    logic                neg_quo;
    logic                neg_rem;
    logic [XLEN:0]       shifted;
    logic [XLEN+1:0]     trial;

    assign start     = launch && (op[4:3] == 2'b11);
    assign is_signed = (op == ex_pkg::OP_DIV) || (op == ex_pkg::OP_MOD);
    assign src1_mag  = (is_signed && src1[XLEN-1]) ? -src1 : src1;
    assign src2_mag  = (is_signed && src2[XLEN-1]) ? -src2 : src2;

    // ======================================================================
    // control
    // ======================================================================
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            state <= IDLE;
        end else if (start) begin
            state <= RUN;
        end else if (state == RUN && count == '0) begin
            state <= FIX; // last iteration happens on this edge.
        end
    end

    // ======================================================================
    // restoring shift and subtract
    // ======================================================================
    assign shifted = {rem_mag, quo_mag[XLEN-1]};
    assign trial   = {1'b0, shifted} - {2'b00, divisor};

    always_ff @(posedge clk) begin
        if (start) begin
            divisor <= src2_mag;
            quo_mag <= src1_mag;
            rem_mag <= '0;
            count   <= CNT_W'(`EX_DIV_CYCLES - 1);
            neg_quo <= is_signed && (src1[XLEN-1] ^ src2[XLEN-1]);
            neg_rem <= is_signed && src1[XLEN-1];
        end else if (state == RUN) begin
            if (trial[XLEN+1]) begin
                rem_mag <= shifted[XLEN-1:0];
                quo_mag <= {quo_mag[XLEN-2:0], 1'b0};
            end else begin
                rem_mag <= trial[XLEN-1:0];
                quo_mag <= {quo_mag[XLEN-2:0], 1'b1};
            end
            count <= count - 1'b1;
        end
    end

    // sign fix is applied while the unit sits in FIX.
    assign quotient  = neg_quo ? -quo_mag : quo_mag;
    assign remainder = neg_rem ? -rem_mag : rem_mag;
    assign done      = (state == FIX) && !start;

endmodule

`default_nettype wire

// File: verilog/ex_issue_reg.sv
`timescale 1ns/1ps
`default_nettype none

module ex_issue_reg (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     flush,
    input  wire                     in_valid,
    input  wire ex_pkg::ex_uop_t    in_uop,
    input  wire                     allowout,
    input  wire                     unit_done,
    output ex_pkg::ex_uop_t         cur,
    output logic                    cur_valid,
    output ex_pkg::ex_class_t       cur_class,
    output logic                    launch,
    output logic                    stall,
    output logic                    out_valid
);

    logic accept;

    assign out_valid = cur_valid && unit_done;
    assign stall     = cur_valid && (!unit_done || !allowout);
    assign accept    = in_valid && !stall;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            cur_valid <= 1'b0;
            launch    <= 1'b0;
        end else begin
            if (!stall) begin
                cur_valid <= in_valid; // the held op leaves as the next one enters.
            end
            launch <= accept;          // first cycle of the new op only.
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            cur <= in_uop;
        end
    end

    // the top two opcode bits name the unit.
    always_comb begin
        case (cur.opcode[4:3])
            2'b10:   cur_class = ex_pkg::CLASS_MUL;
            2'b11:   cur_class = ex_pkg::CLASS_DIV;
            default: cur_class = ex_pkg::CLASS_ALU;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/ex_resolve.sv
`timescale 1ns/1ps
`default_nettype none
`include "ex_cfg.svh"

module ex_resolve (
    input  wire ex_pkg::ex_uop_t       cur,
    input  wire                        cur_valid,
    input  wire ex_pkg::ex_class_t     cur_class,
    input  wire [`EX_XLEN-1:0]         alu_result,
    input  wire                        mul_done,
    input  wire [2*`EX_XLEN-1:0]       mul_product,
    input  wire                        div_done,
    input  wire [`EX_XLEN-1:0]         quotient,
    input  wire [`EX_XLEN-1:0]         remainder,
    input  wire                        out_valid,
    input  wire                        allowout,
    output logic                       unit_done,
    output ex_pkg::ex_result_t         out
);

    logic                   class_done;
    logic [`EX_XLEN-1:0]    unit_result;
    logic                   taken;
    logic [`EX_XLEN-1:0]    target;

    always_comb begin
        case (cur_class)
            ex_pkg::CLASS_MUL: begin
                class_done  = mul_done;
                unit_result = (cur.opcode == ex_pkg::OP_MUL) ?
                              mul_product[`EX_XLEN-1:0] : mul_product[2*`EX_XLEN-1:`EX_XLEN];
            end
            ex_pkg::CLASS_DIV: begin
                class_done  = div_done;
                unit_result = (cur.opcode == ex_pkg::OP_DIV || cur.opcode == ex_pkg::OP_DIVU) ?
                              quotient : remainder;
            end
            default: begin
                class_done  = 1'b1;
                unit_result = alu_result;
            end
        endcase
    end

    assign unit_done = cur_valid && class_done;

    // ======================================================================
    // branch resolution
    // ======================================================================
    assign taken  = cur.is_branch && (cur.is_jirl || cur.branch_condition == alu_result[0]);
    assign target = cur.is_jirl ? alu_result : cur.branch_target;

    assign out.pc            = cur.pc;
    assign out.dest          = cur.dest;
    assign out.result        = cur.is_jirl ? cur.pc + `EX_XLEN'(`EX_PC_STEP) : unit_result;
    assign out.branch_taken  = taken;
    assign out.branch_target = target;
    assign out.mispredict    = out_valid && allowout &&
                               (taken != cur.pred_taken || (taken && target != cur.pred_target));

endmodule

`default_nettype wire

// File: verilog/ex_stage.sv
`timescale 1ns/1ps
`default_nettype none
`include "ex_cfg.svh"

module ex_stage (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     flush,
    input  wire                     in_valid,
    input  wire ex_pkg::ex_uop_t    in_uop,
    input  wire                     allowout,
    output logic                    stall,
    output logic                    out_valid,
    output ex_pkg::ex_result_t      out
);

    ex_pkg::ex_uop_t            cur;
    logic                       cur_valid;
    ex_pkg::ex_class_t          cur_class;
    logic                       launch;
    logic                       unit_done;

    logic [`EX_XLEN-1:0]        alu_result;
    logic                       mul_done;
    logic [2*`EX_XLEN-1:0]      mul_product;
    logic                       div_done;
    logic [`EX_XLEN-1:0]        quotient;
    logic [`EX_XLEN-1:0]        remainder;

    // ======================================================================
    // issue register
    // ======================================================================
    ex_issue_reg u_issue (
        .clk       (clk),
        .rst       (rst),
        .flush     (flush),
        .in_valid  (in_valid),
        .in_uop    (in_uop),
        .allowout  (allowout),
        .unit_done (unit_done),
        .cur       (cur),
        .cur_valid (cur_valid),
        .cur_class (cur_class),
        .launch    (launch),
        .stall     (stall),
        .out_valid (out_valid)
    );

    // ======================================================================
    // execution units
    // ======================================================================
    ex_alu u_alu (
        .op     (cur.opcode),
        .src1   (cur.src1),
        .src2   (cur.src2),
        .result (alu_result)
    );

    ex_mul_unit u_mul (
        .clk     (clk),
        .rst     (rst),
        .launch  (launch),
        .op      (cur.opcode),
        .src1    (cur.src1),
        .src2    (cur.src2),
        .done    (mul_done),
        .product (mul_product)
    );

    ex_div_unit u_div (
        .clk       (clk),
        .rst       (rst),
        .flush     (flush),
        .launch    (launch),
        .op        (cur.opcode),
        .src1      (cur.src1),
        .src2      (cur.src2),
        .done      (div_done),
        .quotient  (quotient),
        .remainder (remainder)
    );

    ex_resolve u_resolve (
        .cur         (cur),
        .cur_valid   (cur_valid),
        .cur_class   (cur_class),
        .alu_result  (alu_result),
        .mul_done    (mul_done),
        .mul_product (mul_product),
        .div_done    (div_done),
        .quotient    (quotient),
        .remainder   (remainder),
        .out_valid   (out_valid),
        .allowout    (allowout),
        .unit_done   (unit_done),
        .out         (out)
    );

endmodule

`default_nettype wire

// File: bench/ex_stage_checker.sv
`timescale 1ns/1ps
`default_nettype none
`include "ex_cfg.svh"

module ex_stage_checker (
    input wire                    clk,
    input wire                    rst,
    input wire                    flush,
    input wire                    cur_valid,
    input wire ex_pkg::ex_class_t cur_class,
    input wire ex_pkg::ex_uop_t   cur,
    input wire                    stall,
    input wire                    out_valid,
    input wire                    launch
);

    // ======================================================================
    // handshake properties
    // ======================================================================

    // a multiply or divide is never complete in its launch cycle.
    valid_needs_done: assert property (@(posedge clk) disable iff (rst)
        (launch && cur_class != ex_pkg::CLASS_ALU) |-> !out_valid)
        else $error("out_valid is high while the unit is still working");

    // the divider is still busy during its last iteration.
    divide_not_early: assert property (@(posedge clk) disable iff (rst || flush)
        (launch && cur_class == ex_pkg::CLASS_DIV) |-> ##(`EX_DIV_CYCLES) !out_valid)
        else $error("a divide finished before its last iteration");

    empty_never_stalls: assert property (@(posedge clk) disable iff (rst)
        flush |=> !stall)
        else $error("stall is high with an empty issue register");

    // the held op stays in place while the stage stalls.
    no_accept_on_stall: assert property (@(posedge clk) disable iff (rst)
        (stall && !flush) |=> (cur_valid && $stable(cur)))
        else $error("an op was accepted while stall was high");

endmodule

`default_nettype wire

// File: bench/tb_ex_stage.sv
`timescale 1ns/1ps
`default_nettype none
`include "ex_cfg.svh"

module tb_ex_stage;

    typedef struct packed {
        ex_pkg::ex_uop_t    uop;
        logic [1:0]         hold;   // cycles allowout stays low after out_valid.
        ex_pkg::ex_result_t exp;
    } entry_t;

    localparam int N_TABLE  = 26;
    localparam int N_RAND   = 8;
    localparam int FLUSH_AT = 15;
    localparam int BUDGET   = (N_TABLE + N_RAND + 2) * (`EX_DIV_CYCLES + 40);

    // ======================================================================
    // stimulus table
    // uop: pc, opcode, src1, src2, dest, is_branch, cond, br_target, jirl,
    //      pred_taken, pred_target
    // exp: pc, dest, result, taken, target, mispredict
    // ======================================================================
    localparam entry_t OPS [N_TABLE] = '{
        '{'{32'h100, ex_pkg::OP_ADD, 32'h5, 32'h7, 5'd0,
            '0, '0, '0, '0, '0, '0}, 2'd0, '{32'h100, 5'd0, 32'hc, '0, '0, '0}},
        '{'{32'h104, ex_pkg::OP_SUB, 32'h3, 32'h5, 5'd1,
            '0, '0, '0, '0, '0, '0}, 2'd1, '{32'h104, 5'd1, 32'hfffffffe, '0, '0, '0}},
        '{'{32'h108, ex_pkg::OP_SLT, 32'hffffffff, 32'h1, 5'd2,
            '0, '0, '0, '0, '0, '0}, 2'd0, '{32'h108, 5'd2, 32'h1, '0, '0, '0}},
        '{'{32'h10c, ex_pkg::OP_SLTU, 32'hffffffff, 32'h1, 5'd3,
            '0, '0, '0, '0, '0, '0}, 2'd0, '{32'h10c, 5'd3, 32'h0, '0, '0, '0}},
        '{'{32'h110, ex_pkg::OP_AND, 32'hf0f0f0f0, 32'hff00ff00, 5'd4,
            '0, '0, '0, '0, '0, '0}, 2'd0, '{32'h110, 5'd4, 32'hf000f000, '0, '0, '0}},
        '{'{32'h114, ex_pkg::OP_OR, 32'h0f0f0000, 32'h000000ff, 5'd5,
            '0, '0, '0, '0, '0, '0}, 2'd0, '{32'h114, 5'd5, 32'h0f0f00ff, '0, '0, '0}},
        '{'{32'h118, ex_pkg::OP_XOR, 32'haaaa5555, 32'hffff0000, 5'd6,
            '0, '0, '0, '0, '0, '0}, 2'd0, '{32'h118, 5'd6, 32'h55555555, '0, '0, '0}},
        '{'{32'h11c, ex_pkg::OP_NOR, 32'h0f0f0f0f, 32'hf0f0f000, 5'd7,
            '0, '0, '0, '0, '0, '0}, 2'd0, '{32'h11c, 5'd7, 32'h000000f0, '0, '0, '0}},
        '{'{32'h120, ex_pkg::OP_SLL, 32'h1, 32'h24, 5'd8,
            '0, '0, '0, '0, '0, '0}, 2'd0, '{32'h120, 5'd8, 32'h10, '0, '0, '0}},
        '{'{32'h124, ex_pkg::OP_SRL, 32'h80000000, 32'h4, 5'd9,
            '0, '0, '0, '0, '0, '0}, 2'd0, '{32'h124, 5'd9, 32'h08000000, '0, '0, '0}},
        '{'{32'h128, ex_pkg::OP_SRA, 32'h80000000, 32'h4, 5'd10,
            '0, '0, '0, '0, '0, '0}, 2'd3, '{32'h128, 5'd10, 32'hf8000000, '0, '0, '0}},
        '{'{32'h12c, ex_pkg::OP_LUI, 32'h0, 32'h12345000, 5'd11,
            '0, '0, '0, '0, '0, '0}, 2'd0, '{32'h12c, 5'd11, 32'h12345000, '0, '0, '0}},
        '{'{32'h130, ex_pkg::OP_MUL, 32'hfffffffe, 32'h3, 5'd12,
            '0, '0, '0, '0, '0, '0}, 2'd0, '{32'h130, 5'd12, 32'hfffffffa, '0, '0, '0}},
        '{'{32'h134, ex_pkg::OP_MULH, 32'hfffffffe, 32'h3, 5'd13,
            '0, '0, '0, '0, '0, '0}, 2'd0, '{32'h134, 5'd13, 32'hffffffff, '0, '0, '0}},
        '{'{32'h138, ex_pkg::OP_MULHU, 32'hfffffffe, 32'h3, 5'd14,
            '0, '0, '0, '0, '0, '0}, 2'd2, '{32'h138, 5'd14, 32'h2, '0, '0, '0}},
        '{'{32'h13c, ex_pkg::OP_DIV, 32'hfffffff9, 32'h2, 5'd15,
            '0, '0, '0, '0, '0, '0}, 2'd0, '{32'h13c, 5'd15, 32'hfffffffd, '0, '0, '0}},
        '{'{32'h140, ex_pkg::OP_DIVU, 32'h64, 32'h7, 5'd16,
            '0, '0, '0, '0, '0, '0}, 2'd0, '{32'h140, 5'd16, 32'he, '0, '0, '0}},
        '{'{32'h144, ex_pkg::OP_MOD, 32'hfffffff9, 32'h2, 5'd17,
            '0, '0, '0, '0, '0, '0}, 2'd1, '{32'h144, 5'd17, 32'hffffffff, '0, '0, '0}},
        '{'{32'h148, ex_pkg::OP_DIV, 32'h7, 32'hfffffffe, 5'd18,
            '0, '0, '0, '0, '0, '0}, 2'd0, '{32'h148, 5'd18, 32'hfffffffd, '0, '0, '0}},
        '{'{32'h14c, ex_pkg::OP_MOD, 32'h7, 32'hfffffffe, 5'd19,
            '0, '0, '0, '0, '0, '0}, 2'd0, '{32'h14c, 5'd19, 32'h1, '0, '0, '0}},
        '{'{32'h150, ex_pkg::OP_SLT, 32'h1, 32'h2, 5'd20,
            '1, '1, 32'h200, '0, '1, 32'h200}, 2'd0, '{32'h150, 5'd20, 32'h1, '1, 32'h200, '0}},
        '{'{32'h154, ex_pkg::OP_SLT, 32'h5, 32'h2, 5'd21,
            '1, '1, 32'h200, '0, '1, 32'h200}, 2'd0, '{32'h154, 5'd21, 32'h0, '0, 32'h200, '1}},
        '{'{32'h158, ex_pkg::OP_SLTU, 32'h1, 32'h2, 5'd22,
            '1, '1, 32'h300, '0, '1, 32'h304}, 2'd0, '{32'h158, 5'd22, 32'h1, '1, 32'h300, '1}},
        '{'{32'h15c, ex_pkg::OP_SLT, 32'h5, 32'h2, 5'd23,
            '1, '0, 32'h400, '0, '0, 32'h0}, 2'd0, '{32'h15c, 5'd23, 32'h0, '1, 32'h400, '1}},
        '{'{32'h160, ex_pkg::OP_ADD, 32'h8000, 32'h10, 5'd24,
            '1, '0, '0, '1, '1, 32'h8010}, 2'd2, '{32'h160, 5'd24, 32'h164, '1, 32'h8010, '0}},
        '{'{32'h164, ex_pkg::OP_ADD, 32'h8000, 32'h10, 5'd25,
            '1, '0, '0, '1, '1, 32'h8000}, 2'd0, '{32'h164, 5'd25, 32'h168, '1, 32'h8010, '1}}
    };

    logic               clk;
    logic               rst;
    logic               flush;
    logic               in_valid;
    logic               allowout;
    ex_pkg::ex_uop_t    in_uop;
    logic               stall;
    logic               out_valid;
    ex_pkg::ex_result_t out;
    logic [31:0]        lfsr;

    ex_stage UUT (
        .clk       (clk),
        .rst       (rst),
        .flush     (flush),
        .in_valid  (in_valid),
        .in_uop    (in_uop),
        .allowout  (allowout),
        .stall     (stall),
        .out_valid (out_valid),
        .out       (out)
    );

    bind ex_stage ex_stage_checker u_checker (
        .clk       (clk),
        .rst       (rst),
        .flush     (flush),
        .cur_valid (cur_valid),
        .cur_class (cur_class),
        .cur       (cur),
        .stall     (stall),
        .out_valid (out_valid),
        .launch    (launch)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        repeat (BUDGET) @(posedge clk);
        $display("watchdog expired after %0d cycles without finishing", BUDGET);
        fail();
    end

    // ======================================================================
    // helpers
    // ======================================================================
    task automatic fail();
        $display("=== FAIL ===");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic compare(input string name, input logic [127:0] got,
                           input logic [127:0] want);
        if (got !== want) begin
            $display("MISMATCH at %0t: %s got %0h expected %0h", $time, name, got, want);
            fail();
        end
    endtask

    // one galois step per returned bit.
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits = {bits[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return bits;
    endfunction

    // truncating division, the remainder follows the dividend's sign.
    function automatic ex_pkg::ex_result_t divide_expect(input ex_pkg::ex_uop_t uop);
        ex_pkg::ex_result_t r;
        longint             a;
        longint             b;
        logic               is_signed;
        is_signed = (uop.opcode == ex_pkg::OP_DIV) || (uop.opcode == ex_pkg::OP_MOD);
        if (is_signed) begin
            a = longint'($signed(uop.src1));
            b = longint'($signed(uop.src2));
        end else begin
            a = longint'(uop.src1);
            b = longint'(uop.src2);
        end
        r = '0;
        r.pc            = uop.pc;
        r.dest          = uop.dest;
        r.branch_target = uop.branch_target;
        if (uop.opcode == ex_pkg::OP_DIV || uop.opcode == ex_pkg::OP_DIVU) begin
            r.result = 32'(a / b);
        end else begin
            r.result = 32'(a % b);
        end
        return r;
    endfunction

    task automatic run_op(input ex_pkg::ex_uop_t uop, input int hold,
                          input ex_pkg::ex_result_t exp);
        ex_pkg::ex_uop_t    decoy;
        ex_pkg::ex_result_t held;
        int                 waited;
        @(negedge clk);
        compare("stall", 128'(stall), 128'(0));
        compare("out_valid", 128'(out_valid), 128'(0));
        in_valid = 1'b1;
        in_uop   = uop;
        allowout = (hold == 0);
        @(negedge clk);
        decoy      = uop;
        decoy.pc   = ~uop.pc;
        decoy.src1 = ~uop.src1;
        in_valid   = (hold != 0); // a second op stays offered while held.
        in_uop     = decoy;
        waited     = 0;
        #1;
        while (!out_valid) begin
            @(negedge clk);
            #1;
            waited++;
            if (waited > `EX_DIV_CYCLES + 8) begin
                $display("out_valid never rose for the op at pc %0h", uop.pc);
                fail();
            end
        end
        if (hold != 0) begin
            held = out;
            for (int i = 0; i < hold; i++) begin
                @(negedge clk);
                #1;
                compare("stall", 128'(stall), 128'(1));
                compare("out", 128'(out), 128'(held));
            end
            @(negedge clk);
            in_valid = 1'b0;
            allowout = 1'b1;
            #1;
        end
        compare("out.pc", 128'(out.pc), 128'(exp.pc));
        compare("out.dest", 128'(out.dest), 128'(exp.dest));
        compare("out.result", 128'(out.result), 128'(exp.result));
        compare("out.branch_taken", 128'(out.branch_taken), 128'(exp.branch_taken));
        compare("out.branch_target", 128'(out.branch_target), 128'(exp.branch_target));
        compare("out.mispredict", 128'(out.mispredict), 128'(exp.mispredict));
    endtask

    task automatic flush_divide();
        ex_pkg::ex_uop_t uop;
        uop        = '0;
        uop.opcode = ex_pkg::OP_DIVU;
        uop.src1   = 32'h1234;
        uop.src2   = 32'h5;
        @(negedge clk);
        in_valid = 1'b1;
        in_uop   = uop;
        @(negedge clk);
        in_valid = 1'b0;
        repeat (`EX_DIV_CYCLES / 2) @(negedge clk);
        compare("out_valid", 128'(out_valid), 128'(0));
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        repeat (`EX_DIV_CYCLES + 4) begin
            #1;
            compare("out_valid", 128'(out_valid), 128'(0));
            compare("stall", 128'(stall), 128'(0));
            @(negedge clk);
        end
    endtask

    // ======================================================================
    // main sequence
    // ======================================================================
    initial begin
        ex_pkg::ex_uop_t uop;
        lfsr     = 32'hf131;
        rst      = 1'b1;
        flush    = 1'b0;
        in_valid = 1'b0;
        allowout = 1'b1;
        in_uop   = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        compare("out_valid", 128'(out_valid), 128'(0));
        compare("stall", 128'(stall), 128'(0));
        compare("out.mispredict", 128'(out.mispredict), 128'(0));
        rst = 1'b0;

        for (int i = 0; i < N_TABLE; i++) begin
            if (i == FLUSH_AT) begin
                flush_divide();
            end
            run_op(OPS[i].uop, int'(OPS[i].hold), OPS[i].exp);
        end

        for (int i = 0; i < N_RAND; i++) begin
            uop        = '0;
            uop.pc     = 32'h800 + 32'(4 * i);
            uop.dest   = 5'(i);
            uop.opcode = ex_pkg::ex_opcode_t'({3'b110, 2'(take_bits(2))});
            uop.src1   = take_bits(32);
            uop.src2   = take_bits(32);
            if (uop.src2 == '0) begin
                uop.src2 = 32'h1;
            end
            run_op(uop, int'(take_bits(2)), divide_expect(uop));
        end

        @(negedge clk);
        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
+incdir+verilog
verilog/ex_pkg.sv
verilog/ex_alu.sv
verilog/ex_mul_unit.sv
verilog/ex_div_unit.sv
verilog/ex_issue_reg.sv
verilog/ex_resolve.sv
verilog/ex_stage.sv
bench/ex_stage_checker.sv
bench/tb_ex_stage.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_ex_stage \
    -f project.f -o sim_ex_stage

output=$(./obj_dir/sim_ex_stage 2>&1) || true
echo "$output"

if echo "$output" | grep -q "=== PASS ==="; then
    exit 0
fi
exit 1
